// File: src/mdp_pkg.sv
package mdp_pkg;

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned CSR_ADDR_W = 12;

  // major opcodes seen by this pipeline
  typedef enum logic [6:0] {
    OPCODE_OP     = 7'h33,
    OPCODE_SYSTEM = 7'h73
  } opcode_e;

  typedef enum logic [1:0] {
    MD_OP_MULL = 2'b00,
    MD_OP_MULH = 2'b01,
    MD_OP_DIV  = 2'b10,
    MD_OP_REM  = 2'b11
  } md_op_e;

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  typedef enum logic [4:0] {
    EXC_NONE         = 5'd0,
    EXC_ILLEGAL_INSN = 5'd2
  } exc_cause_e;

  // EX1 to arithmetic units
  typedef struct packed {
    logic            mult_en;
    logic            div_en;
    md_op_e          op;
    logic [1:0]      signed_mode;
    logic [XLEN-1:0] op_a;
  } md_cmd_t;

  typedef struct packed {
    logic                  is_mult;
    logic                  is_div;
    logic                  is_csr;
    logic                  is_illegal;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rd;
    logic [31:0]           insn;
    logic [XLEN-1:0]       csr_wdata;
  } ex2_reg_t;

  typedef struct packed {
    logic                  en;
    csr_op_e               op;
    logic [CSR_ADDR_W-1:0] addr;
    logic [XLEN-1:0]       wdata;
  } csr_req_t;

  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
    logic                  err;
    exc_cause_e            mcause;
  } wb_out_t;

endpackage

// File: src/md_decoder.sv
`timescale 1ns/10ps

module md_decoder (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic [31:0]                 insn_i,
  input  logic [mdp_pkg::XLEN-1:0]    op_a_i,
  input  logic                        us_valid_i,
  input  logic                        ex2_load_i,
  output mdp_pkg::md_cmd_t            md_cmd_o,
  output mdp_pkg::ex2_reg_t           ex2_reg_o
);

  mdp_pkg::opcode_e  opcode;
  mdp_pkg::md_op_e   md_op;
  mdp_pkg::ex2_reg_t ex2_d;
  logic [6:0]        funct7;
  logic [2:0]        funct3;
  logic              is_md;
  logic              is_csr;
  logic [1:0]        signed_mode;

  assign opcode = mdp_pkg::opcode_e'(insn_i[6:0]);
  assign funct7 = insn_i[31:25];
  assign funct3 = insn_i[14:12];

  assign is_md  = (opcode == mdp_pkg::OPCODE_OP) && (funct7 == 7'b000_0001);
  // funct3 of zero is ecall/ebreak/mret territory
  assign is_csr = (opcode == mdp_pkg::OPCODE_SYSTEM) && (funct3 != 3'b000);

  // funct3[2] splits mul from div, funct3[1] splits div from rem
  always_comb begin
    if (funct3[2]) begin
      md_op = funct3[1] ? mdp_pkg::MD_OP_REM : mdp_pkg::MD_OP_DIV;
    end else begin
      md_op = (funct3[1:0] == 2'b00) ? mdp_pkg::MD_OP_MULL : mdp_pkg::MD_OP_MULH;
    end
    unique case (funct3)
      3'b001, 3'b100, 3'b110: signed_mode = 2'b11;
      3'b010:                 signed_mode = 2'b10;
      default:                signed_mode = 2'b00;
    endcase
  end

  // start strobes only on a real acceptance
  assign md_cmd_o.mult_en     = us_valid_i & ex2_load_i & is_md & ~funct3[2];
  assign md_cmd_o.div_en      = us_valid_i & ex2_load_i & is_md & funct3[2];
  assign md_cmd_o.op          = md_op;
  assign md_cmd_o.signed_mode = signed_mode;
  assign md_cmd_o.op_a        = op_a_i;

  assign ex2_d.is_mult    = is_md & ~funct3[2];
  assign ex2_d.is_div     = is_md & funct3[2];
  assign ex2_d.is_csr     = is_csr;
  assign ex2_d.is_illegal = ~is_md & ~is_csr;
  assign ex2_d.rf_we      = is_md | is_csr;
  assign ex2_d.rd         = insn_i[11:7];
  assign ex2_d.insn       = insn_i;
  // zimm forms take rs1 field as data
  assign ex2_d.csr_wdata  = insn_i[14] ? {{(mdp_pkg::XLEN-5){1'b0}}, insn_i[19:15]} : op_a_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ex2_reg_o <= '0;
    end else if (ex2_load_i) begin
      ex2_reg_o <= ex2_d;
    end
  end

endmodule

// File: src/md_multiplier.sv
`timescale 1ns/10ps

module md_multiplier (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  mdp_pkg::md_cmd_t            md_cmd_i,
  input  logic [mdp_pkg::XLEN-1:0]    op_b_i,
  output logic [mdp_pkg::XLEN-1:0]    mult_result_o
);

  logic signed [mdp_pkg::XLEN:0]     op_a_ext;
  logic signed [mdp_pkg::XLEN:0]     op_b_ext;
  logic signed [2*mdp_pkg::XLEN+1:0] product;
  logic        [mdp_pkg::XLEN-1:0]   result_d;

  // extra top bit makes all four sign combinations one signed multiply
  assign op_a_ext = {md_cmd_i.signed_mode[1] & md_cmd_i.op_a[mdp_pkg::XLEN-1], md_cmd_i.op_a};
  assign op_b_ext = {md_cmd_i.signed_mode[0] & op_b_i[mdp_pkg::XLEN-1], op_b_i};
  assign product  = op_a_ext * op_b_ext;

  assign result_d = (md_cmd_i.op == mdp_pkg::MD_OP_MULH) ?
                    product[2*mdp_pkg::XLEN-1:mdp_pkg::XLEN] :
                    product[mdp_pkg::XLEN-1:0];

  // held while the instruction waits in EX2
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mult_result_o <= '0;
    end else if (md_cmd_i.mult_en) begin
      mult_result_o <= result_d;
    end
  end

endmodule

// File: src/md_divider.sv
`timescale 1ns/10ps

module md_divider (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  mdp_pkg::md_cmd_t            md_cmd_i,
  input  logic [mdp_pkg::XLEN-1:0]    op_b_i,
  input  logic                        kill_i,
  output logic                        div_done_o,
  output logic [mdp_pkg::XLEN-1:0]    div_result_o
);

  typedef enum logic [1:0] {
    IDLE = 2'b00,
    BUSY = 2'b01,
    DONE = 2'b10
  } div_state_e;

  div_state_e                  state_q;
  logic [4:0]                  count_q;
  logic [mdp_pkg::XLEN-1:0]    quo_q;
  logic [mdp_pkg::XLEN-1:0]    rem_q;
  logic [mdp_pkg::XLEN-1:0]    divisor_q;
  logic                        neg_q_q;
  logic                        neg_r_q;
  logic                        is_rem_q;

  logic                        sign_a;
  logic                        sign_b;
  logic [mdp_pkg::XLEN-1:0]    mag_a;
  logic [mdp_pkg::XLEN-1:0]    mag_b;
  logic [mdp_pkg::XLEN:0]      rem_shift;
  logic [mdp_pkg::XLEN:0]      diff;

  assign sign_a = md_cmd_i.signed_mode[1] & md_cmd_i.op_a[mdp_pkg::XLEN-1];
  assign sign_b = md_cmd_i.signed_mode[0] & op_b_i[mdp_pkg::XLEN-1];
  assign mag_a  = sign_a ? -md_cmd_i.op_a : md_cmd_i.op_a;
  assign mag_b  = sign_b ? -op_b_i : op_b_i;

  // one restoring step, next dividend bit comes from the top of quo_q
  assign rem_shift = {rem_q, quo_q[mdp_pkg::XLEN-1]};
  assign diff      = rem_shift - {1'b0, divisor_q};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      count_q <= '0;
    end else if (kill_i) begin
      state_q <= IDLE;
    end else if (md_cmd_i.div_en) begin
      state_q <= BUSY;
      count_q <= '0;
    end else if (state_q == BUSY) begin
      count_q <= count_q + 5'd1;
      if (count_q == 5'd31) begin
        state_q <= DONE;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (md_cmd_i.div_en) begin
      quo_q     <= mag_a;
      rem_q     <= '0;
      divisor_q <= mag_b;
      // x/0 keeps all ones, so no negation there
      neg_q_q   <= (sign_a ^ sign_b) & (op_b_i != '0);
      neg_r_q   <= sign_a;
      is_rem_q  <= (md_cmd_i.op == mdp_pkg::MD_OP_REM);
    end else if (state_q == BUSY) begin
      if (!diff[mdp_pkg::XLEN]) begin
        rem_q <= diff[mdp_pkg::XLEN-1:0];
        quo_q <= {quo_q[mdp_pkg::XLEN-2:0], 1'b1};
      end else begin
        rem_q <= rem_shift[mdp_pkg::XLEN-1:0];
        quo_q <= {quo_q[mdp_pkg::XLEN-2:0], 1'b0};
      end
    end
  end

  assign div_done_o = (state_q == DONE);

  // sign fix-up; min/-1 falls out as 0x8000_0000 rem 0
  assign div_result_o = is_rem_q ? (neg_r_q ? -rem_q : rem_q) :
                                   (neg_q_q ? -quo_q : quo_q);

endmodule

// File: src/csr_access.sv
`timescale 1ns/10ps

module csr_access (
  input  mdp_pkg::ex2_reg_t   ex2_reg_i,
  input  logic                ex2_valid_i,
  input  logic                illegal_csr_i,
  output mdp_pkg::csr_req_t   csr_req_o,
  output logic                csr_err_o
);

  logic rs1_zero;
  logic csr_en;

  // also covers a zero zimm
  assign rs1_zero = (ex2_reg_i.insn[19:15] == 5'd0);
  assign csr_en   = ex2_valid_i & ex2_reg_i.is_csr;

  always_comb begin
    unique case (ex2_reg_i.insn[13:12])
      2'b01: begin
        csr_req_o.op = mdp_pkg::CSR_OP_WRITE;
      end
      2'b10: begin
        csr_req_o.op = rs1_zero ? mdp_pkg::CSR_OP_READ : mdp_pkg::CSR_OP_SET;
      end
      2'b11: begin
        csr_req_o.op = rs1_zero ? mdp_pkg::CSR_OP_READ : mdp_pkg::CSR_OP_CLEAR;
      end
      default: begin
        csr_req_o.op = mdp_pkg::CSR_OP_READ;
      end
    endcase
  end

  assign csr_req_o.en    = csr_en;
  assign csr_req_o.addr  = ex2_reg_i.insn[31:20];
  assign csr_req_o.wdata = ex2_reg_i.csr_wdata;

  assign csr_err_o = csr_en & illegal_csr_i;

endmodule

// File: src/pipe_ctrl.sv
`timescale 1ns/10ps

module pipe_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                us_valid_i,
  input  logic                flush_i,
  input  logic                ds_rdy_i,
  input  mdp_pkg::ex2_reg_t   ex2_reg_i,
  input  logic                div_done_i,
  output logic                ex2_load_o,
  output logic                wb_load_o,
  output logic                ex2_valid_o,
  output logic                wb_valid_o
);

  logic ex2_valid_q;
  logic wb_valid_q;
  logic op_done;
  logic op_done_q;
  logic ex2_rdy;
  logic wb_rdy;

  // everything but division finishes in its first EX2 cycle
  assign op_done = ex2_reg_i.is_mult | ex2_reg_i.is_csr | ex2_reg_i.is_illegal |
                   (ex2_reg_i.is_div & div_done_i) | op_done_q;

  assign wb_rdy  = ~wb_valid_q | ds_rdy_i;
  assign ex2_rdy = ~ex2_valid_q | (op_done & wb_rdy);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ex2_valid_q <= 1'b0;
      wb_valid_q  <= 1'b0;
    end else if (flush_i) begin
      ex2_valid_q <= 1'b0;
      wb_valid_q  <= 1'b0;
    end else begin
      if (ex2_rdy) begin
        ex2_valid_q <= us_valid_i;
      end
      if (wb_rdy) begin
        wb_valid_q <= ex2_valid_q & op_done;
      end
    end
  end

  // remember completion while WB is stalled
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_done_q <= 1'b0;
    end else if (flush_i || ex2_rdy) begin
      op_done_q <= 1'b0;
    end else if (ex2_valid_q && op_done) begin
      op_done_q <= 1'b1;
    end
  end

  assign ex2_load_o  = ex2_rdy;
  assign wb_load_o   = ex2_valid_q & op_done & wb_rdy;
  assign ex2_valid_o = ex2_valid_q;
  assign wb_valid_o  = wb_valid_q;

endmodule

// File: src/wb_stage.sv
`timescale 1ns/10ps

module wb_stage (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        wb_load_i,
  input  mdp_pkg::ex2_reg_t           ex2_reg_i,
  input  logic [mdp_pkg::XLEN-1:0]    mult_result_i,
  input  logic [mdp_pkg::XLEN-1:0]    div_result_i,
  input  logic [mdp_pkg::XLEN-1:0]    csr_rdata_i,
  input  logic                        csr_err_i,
  output mdp_pkg::wb_out_t            out_o
);

  mdp_pkg::wb_out_t wb_d;
  logic             err;

  assign err = ex2_reg_i.is_illegal | csr_err_i;

  // illegal instructions fall through to zero data
  always_comb begin
    if (ex2_reg_i.is_csr) begin
      wb_d.wdata = csr_rdata_i;
    end else if (ex2_reg_i.is_mult) begin
      wb_d.wdata = mult_result_i;
    end else if (ex2_reg_i.is_div) begin
      wb_d.wdata = div_result_i;
    end else begin
      wb_d.wdata = '0;
    end
  end

  assign wb_d.we     = ex2_reg_i.rf_we & ~err;
  assign wb_d.waddr  = ex2_reg_i.rd;
  assign wb_d.err    = err;
  assign wb_d.mcause = err ? mdp_pkg::EXC_ILLEGAL_INSN : mdp_pkg::EXC_NONE;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_o <= '0;
    end else if (wb_load_i) begin
      out_o <= wb_d;
    end
  end

endmodule

// File: src/muldiv_pipeline.sv
`timescale 1ns/10ps

module muldiv_pipeline (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        flush_i,
  input  logic                        us_valid_i,
  output logic                        rdy_o,
  input  logic [31:0]                 insn_i,
  input  logic [mdp_pkg::XLEN-1:0]    op_a_i,
  input  logic [mdp_pkg::XLEN-1:0]    op_b_i,
  input  logic                        ds_rdy_i,
  output logic                        valid_o,
  output mdp_pkg::wb_out_t            out_o,
  output mdp_pkg::csr_req_t           csr_req_o,
  input  logic [mdp_pkg::XLEN-1:0]    csr_rdata_i,
  input  logic                        illegal_csr_i
);

  mdp_pkg::md_cmd_t            md_cmd;
  mdp_pkg::ex2_reg_t           ex2_reg;
  logic                        ex2_load;
  logic                        wb_load;
  logic                        ex2_valid;
  logic                        div_done;
  logic                        csr_err;
  logic [mdp_pkg::XLEN-1:0]    mult_result;
  logic [mdp_pkg::XLEN-1:0]    div_result;

  assign rdy_o = ex2_load;

  md_decoder md_decoder_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .insn_i     (insn_i),
    .op_a_i     (op_a_i),
    .us_valid_i (us_valid_i),
    .ex2_load_i (ex2_load),
    .md_cmd_o   (md_cmd),
    .ex2_reg_o  (ex2_reg)
  );

  md_multiplier md_multiplier_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .md_cmd_i      (md_cmd),
    .op_b_i        (op_b_i),
    .mult_result_o (mult_result)
  );

  // a flush aborts any division in flight
  md_divider md_divider_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .md_cmd_i     (md_cmd),
    .op_b_i       (op_b_i),
    .kill_i       (flush_i),
    .div_done_o   (div_done),
    .div_result_o (div_result)
  );

  csr_access csr_access_inst (
    .ex2_reg_i     (ex2_reg),
    .ex2_valid_i   (ex2_valid),
    .illegal_csr_i (illegal_csr_i),
    .csr_req_o     (csr_req_o),
    .csr_err_o     (csr_err)
  );

  pipe_ctrl pipe_ctrl_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .us_valid_i  (us_valid_i),
    .flush_i     (flush_i),
    .ds_rdy_i    (ds_rdy_i),
    .ex2_reg_i   (ex2_reg),
    .div_done_i  (div_done),
    .ex2_load_o  (ex2_load),
    .wb_load_o   (wb_load),
    .ex2_valid_o (ex2_valid),
    .wb_valid_o  (valid_o)
  );

  wb_stage wb_stage_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .wb_load_i     (wb_load),
    .ex2_reg_i     (ex2_reg),
    .mult_result_i (mult_result),
    .div_result_i  (div_result),
    .csr_rdata_i   (csr_rdata_i),
    .csr_err_i     (csr_err),
    .out_o         (out_o)
  );

endmodule

// File: tb/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// CSR environment, read data is a fixed hash of the address
function automatic logic [31:0] csr_read_data(input logic [11:0] addr);
  return ({20'd0, addr} * 32'h9E37_79B1) ^ 32'hA5A5_0F0F;
endfunction

// 0x7C0 to 0x7CF do not exist
function automatic logic csr_is_illegal(input logic [11:0] addr);
  return addr[11:4] == 8'h7C;
endfunction

function automatic logic is_csr_insn(input logic [31:0] insn);
  return (insn[6:0] == 7'h73) && (insn[14:12] != 3'd0);
endfunction

function automatic mdp_pkg::csr_req_t ref_csr_req(input logic [31:0] insn,
                                                  input logic [31:0] a);
  mdp_pkg::csr_req_t req;
  req.en    = 1'b1;
  req.addr  = insn[31:20];
  req.wdata = insn[14] ? {27'd0, insn[19:15]} : a;
  // set and clear with a zero source only read
  case (insn[13:12])
    2'b01:   req.op = mdp_pkg::CSR_OP_WRITE;
    2'b10:   req.op = (insn[19:15] == 5'd0) ? mdp_pkg::CSR_OP_READ : mdp_pkg::CSR_OP_SET;
    2'b11:   req.op = (insn[19:15] == 5'd0) ? mdp_pkg::CSR_OP_READ : mdp_pkg::CSR_OP_CLEAR;
    default: req.op = mdp_pkg::CSR_OP_READ;
  endcase
  return req;
endfunction

// expected WB output from the RV32M and CSR rules
function automatic mdp_pkg::wb_out_t ref_result(input logic [31:0] insn,
                                                input logic [31:0] a,
                                                input logic [31:0] b);
  mdp_pkg::wb_out_t res;
  logic [63:0]      prod_ss;
  logic [63:0]      prod_su;
  logic [63:0]      prod_uu;
  logic [31:0]      quo;
  logic [31:0]      rem;
  logic [31:0]      quou;
  logic [31:0]      remu;
  int               sa;
  int               sb;
  sa      = $signed(a);
  sb      = $signed(b);
  prod_ss = {{32{a[31]}}, a} * {{32{b[31]}}, b};
  prod_su = {{32{a[31]}}, a} * {32'd0, b};
  prod_uu = {32'd0, a} * {32'd0, b};
  if (b == 32'd0) begin
    quo = '1;
    rem = a;
  end else if ((a == 32'h8000_0000) && (b == 32'hFFFF_FFFF)) begin
    quo = 32'h8000_0000;
    rem = 32'd0;
  end else begin
    quo = sa / sb;
    rem = sa % sb;
  end
  quou = (b == 32'd0) ? '1 : a / b;
  remu = (b == 32'd0) ? a : a % b;
  res.waddr = insn[11:7];
  res.wdata = 32'd0;
  res.err   = 1'b0;
  if ((insn[6:0] == 7'h33) && (insn[31:25] == 7'h01)) begin
    case (insn[14:12])
      3'd0:    res.wdata = prod_uu[31:0];
      3'd1:    res.wdata = prod_ss[63:32];
      3'd2:    res.wdata = prod_su[63:32];
      3'd3:    res.wdata = prod_uu[63:32];
      3'd4:    res.wdata = quo;
      3'd5:    res.wdata = quou;
      3'd6:    res.wdata = rem;
      default: res.wdata = remu;
    endcase
  end else if (is_csr_insn(insn)) begin
    res.wdata = csr_read_data(insn[31:20]);
    res.err   = csr_is_illegal(insn[31:20]);
  end else begin
    res.err = 1'b1;
  end
  res.we     = ~res.err;
  res.mcause = res.err ? mdp_pkg::EXC_ILLEGAL_INSN : mdp_pkg::EXC_NONE;
  return res;
endfunction

`endif

// File: tb/tb_muldiv_pipeline.sv
`timescale 1ns/10ps

module tb_muldiv_pipeline;

  `include "tb_ref_model.svh"

  localparam int NUM_RANDOM = 300;
  // two flush runs of four instructions each
  localparam int NUM_INSN   = NUM_RANDOM + 8;

  logic              clk_i;
  logic              rst_ni;
  logic              flush_i;
  logic              us_valid_i;
  logic              rdy_o;
  logic [31:0]       insn_i;
  logic [31:0]       op_a_i;
  logic [31:0]       op_b_i;
  logic              ds_rdy_i;
  logic              valid_o;
  mdp_pkg::wb_out_t  out_o;
  mdp_pkg::csr_req_t csr_req_o;
  logic [31:0]       csr_rdata_i;
  logic              illegal_csr_i;

  logic [31:0]       lfsr_q;
  mdp_pkg::wb_out_t  exp_q[$];

  // CSR side answers in the same cycle
  assign csr_rdata_i   = csr_read_data(csr_req_o.addr);
  assign illegal_csr_i = csr_req_o.en & csr_is_illegal(csr_req_o.addr);

  muldiv_pipeline muldiv_pipeline_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .us_valid_i    (us_valid_i),
    .rdy_o         (rdy_o),
    .insn_i        (insn_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .ds_rdy_i      (ds_rdy_i),
    .valid_o       (valid_o),
    .out_o         (out_o),
    .csr_req_o     (csr_req_o),
    .csr_rdata_i   (csr_rdata_i),
    .illegal_csr_i (illegal_csr_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic draw_bits(input int n, output logic [31:0] val);
    int i;
    val = '0;
    for (i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
  endtask

  task automatic random_insn(output logic [31:0] insn, output logic [31:0] a,
                             output logic [31:0] b);
    logic [31:0] kind;
    logic [31:0] f3;
    logic [31:0] rd;
    logic [31:0] rs;
    logic [31:0] sel;
    logic [31:0] addr;
    logic [4:0]  rs1;
    draw_bits(3, kind);
    draw_bits(3, f3);
    draw_bits(5, rd);
    draw_bits(10, rs);
    draw_bits(32, a);
    draw_bits(32, b);
    draw_bits(3, sel);
    // divider corner operands now and then
    if (sel == 32'd0) begin
      b = '0;
    end else if (sel == 32'd1) begin
      a = 32'h8000_0000;
      b = '1;
    end
    if (kind < 32'd5) begin
      insn = {7'h01, rs[9:0], f3[2:0], rd[4:0], 7'h33};
    end else if (kind < 32'd7) begin
      draw_bits(2, sel);
      draw_bits(12, addr);
      case (sel[1:0])
        2'd0:    addr = {20'd0, 8'h7C, addr[3:0]};
        2'd1:    addr = 32'h300;
        2'd2:    addr = 32'h341;
        default: addr = {20'd0, addr[11:0]};
      endcase
      rs1 = rs[9] ? 5'd0 : rs[4:0];
      if (f3[1:0] == 2'd0) begin
        f3[1:0] = 2'd1;
      end
      insn = {addr[11:0], rs1, f3[2:0], rd[4:0], 7'h73};
    end else begin
      case (f3[1:0])
        2'd0:    insn = {7'h00, rs[9:0], f3[2:0], rd[4:0], 7'h33};
        2'd1:    insn = {7'h20, rs[9:0], f3[2:0], rd[4:0], 7'h33};
        2'd2:    insn = {20'd0, rd[4:0], 7'h73};
        default: insn = {7'h00, rs[9:0], f3[2:0], rd[4:0], 7'h03};
      endcase
    end
  endtask

  // called just after a falling edge, returns just after one
  task automatic issue(input logic [31:0] insn, input logic [31:0] a, input logic [31:0] b,
                       input logic random_bp);
    logic [31:0] r;
    logic        taken;
    taken      = 1'b0;
    insn_i     = insn;
    op_a_i     = a;
    op_b_i     = b;
    us_valid_i = 1'b1;
    while (!taken) begin
      if (random_bp) begin
        draw_bits(2, r);
        ds_rdy_i = (r[1:0] != 2'd0);
      end
      @(posedge clk_i);
      taken = rdy_o;
      @(negedge clk_i);
    end
    us_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    ds_rdy_i = 1'b1;
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
  endtask

  task automatic flush_run(input int hold_cycles);
    logic [31:0] a;
    logic [31:0] b;
    ds_rdy_i = 1'b0;
    draw_bits(32, a);
    draw_bits(32, b);
    issue({7'h01, 10'd0, 3'd1, 5'd3, 7'h33}, a, b, 1'b0);
    issue({7'h01, 10'd0, 3'd4, 5'd4, 7'h33}, a, b, 1'b0);
    repeat (hold_cycles) @(negedge clk_i);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    check_value("valid_o", valid_o, 1'b0);
    ds_rdy_i = 1'b1;
    draw_bits(32, a);
    draw_bits(32, b);
    issue({7'h01, 10'd0, 3'd4, 5'd5, 7'h33}, a, b, 1'b0);
    issue({7'h01, 10'd0, 3'd0, 5'd6, 7'h33}, b, a, 1'b0);
    wait_drain();
  endtask

  initial begin : driver
    logic [31:0] insn;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] gap;
    int          n;
    lfsr_q     = 32'h9498_2063;
    rst_ni     = 1'b0;
    flush_i    = 1'b0;
    us_valid_i = 1'b0;
    insn_i     = '0;
    op_a_i     = '0;
    op_b_i     = '0;
    ds_rdy_i   = 1'b0;
    repeat (3) @(negedge clk_i);
    check_value("rdy_o", rdy_o, 1'b1);
    check_value("valid_o", valid_o, 1'b0);
    check_value("csr_req_o.en", csr_req_o.en, 1'b0);
    rst_ni = 1'b1;
    @(negedge clk_i);
    for (n = 0; n < NUM_RANDOM; n++) begin
      draw_bits(2, gap);
      repeat (gap) begin
        draw_bits(2, a);
        ds_rdy_i = (a[1:0] != 2'd0);
        @(negedge clk_i);
      end
      random_insn(insn, a, b);
      issue(insn, a, b, 1'b1);
    end
    wait_drain();
    // first aborts a running divide, second a finished one held in EX2
    flush_run(5);
    flush_run(40);
    $display("Done: no errors");
    $finish;
  end

  // reads pre-edge values at every rising edge
  initial begin : monitor
    mdp_pkg::wb_out_t  exp;
    mdp_pkg::wb_out_t  held;
    mdp_pkg::csr_req_t ex2_req;
    logic              ex2_csr;
    logic              hold_armed;
    ex2_csr    = 1'b0;
    ex2_req    = '0;
    held       = '0;
    hold_armed = 1'b0;
    @(posedge rst_ni);
    forever begin
      @(posedge clk_i);
      if (hold_armed) begin
        check_value("valid_o", valid_o, 1'b1);
        check_value("out_o", out_o, held);
      end
      hold_armed = valid_o && !ds_rdy_i && !flush_i;
      held       = out_o;
      check_value("csr_req_o.en", csr_req_o.en, ex2_csr);
      if (csr_req_o.en) begin
        check_value("csr_req_o.op", csr_req_o.op, ex2_req.op);
        check_value("csr_req_o.addr", csr_req_o.addr, ex2_req.addr);
        check_value("csr_req_o.wdata", csr_req_o.wdata, ex2_req.wdata);
      end
      if (valid_o && ds_rdy_i) begin
        if (exp_q.size() == 0) begin
          stop_with_failure("result delivered with no instruction in flight");
        end else begin
          exp = exp_q.pop_front();
          check_value("out_o.we", out_o.we, exp.we);
          check_value("out_o.waddr", out_o.waddr, exp.waddr);
          check_value("out_o.wdata", out_o.wdata, exp.wdata);
          check_value("out_o.err", out_o.err, exp.err);
          check_value("out_o.mcause", out_o.mcause, exp.mcause);
        end
      end
      // track what EX2 holds for the CSR request check
      if (flush_i) begin
        exp_q.delete();
        ex2_csr = 1'b0;
      end else if (rdy_o) begin
        ex2_csr = us_valid_i && is_csr_insn(insn_i);
        ex2_req = ref_csr_req(insn_i, op_a_i);
        if (us_valid_i) begin
          exp_q.push_back(ref_result(insn_i, op_a_i, op_b_i));
        end
      end
    end
  end

  initial begin : watchdog
    repeat (NUM_INSN * 40) @(posedge clk_i);
    stop_with_failure("timeout while waiting for the pipeline");
  end

endmodule

// File: flist.f
+incdir+tb
src/mdp_pkg.sv
src/md_decoder.sv
src/md_multiplier.sv
src/md_divider.sv
src/csr_access.sv
src/pipe_ctrl.sv
src/wb_stage.sv
src/muldiv_pipeline.sv
tb/tb_muldiv_pipeline.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
TOP       ?= tb_muldiv_pipeline
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Done: no errors" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
